// ==== rv_pipe.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_pipe_top.sv
verif/rv_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build rv_pipe with Verilator, run the testbench, then read the verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module rv_pipe_tb -f rv_pipe.f -o rv_pipe_sim \
    && ./obj_dir/rv_pipe_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation passed"

// ==== verif/rv_pipe_tb.sv ====
// testbench for rv_pipe_top, runs a seeded random program against an instruction-level model
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module rv_pipe_tb;

    localparam int half_period  = 2;      // 4 ns clock
    localparam int drive_dly    = 1;      // inputs move this long after the edge
    localparam int body_len     = 200;
    localparam int dmem_words   = 64;
    localparam int imem_words   = 1 << `RV_IMEM_AW;
    localparam int run_timeout  = 20000;
    localparam int quiet_cycles = 200;

    // program entries, kept in decoded form for the model
    typedef enum logic [3:0] {
        k_add, k_sub, k_and, k_or, k_xor,
        k_addi, k_andi, k_ori, k_xori,
        k_lw, k_sw,
        k_beq, k_bne, k_blt, k_bge
    } kind_e;

    typedef struct packed {
        kind_e                 kind;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;    // sign extended, byte offset for branches
    } instr_t;

    // one bus transfer as seen on the data port
    typedef struct packed {
        logic                we;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;
    } xfer_t;

    logic                   clk;
    logic                   reset_b;
    logic [`RV_IMEM_AW-1:0] imem_addr;
    logic [`RV_XLEN-1:0]    imem_data;
    pipe_pkg::wb_m2s_t      wb_m;
    pipe_pkg::wb_s2m_t      wb_s = '0;

    logic [`RV_XLEN-1:0]    imem [0:imem_words-1];
    logic [`RV_XLEN-1:0]    dmem [0:dmem_words-1];        // responder side
    logic [`RV_XLEN-1:0]    model_mem [0:dmem_words-1];   // model side
    instr_t                 prog [0:imem_words-1];
    xfer_t                  exp_q [$];                    // model's ordered transfers

    integer seed = 7494;
    int     prog_len = 0;
    int     halt_idx = 0;
    int     model_stores = 0;
    int     xfer_cnt = 0;
    int     store_cnt = 0;
    int     cycles;
    logic   busy = 1'b0;
    int     wait_left = 0;
    xfer_t  held = '0;                                    // request being served

    rv_pipe_top u_rv_pipe_top (
        .clk       (clk),
        .reset_b   (reset_b),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_m      (wb_m),
        .wb_s      (wb_s)
    );

    assign imem_data = imem[imem_addr];   // same-cycle instruction answer

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // --------------------
    // reporting
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                     name, got, exp));
        end
    endtask

    // --------------------
    // random helpers and program builder
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % unsigned'(n));
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [31:0] r;
        r = $random(seed);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] byte_adr);
        return (byte_adr * 32'h9e37_79b1) ^ {byte_adr[15:0], ~byte_adr[15:0]};
    endfunction

    task automatic emit(input instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        instr_t ins;
        int     r;
        int     sel;
        int     n;
        int     body_end;
        for (r = 1; r < 16; r++) begin   // seed x1..x15, regfile has no reset
            ins = '{kind: k_addi, rd: 5'(r), rs1: '0, rs2: '0, imm: rand_imm12()};
            emit(ins);
        end
        body_end = prog_len + body_len;
        while (prog_len < body_end) begin
            ins     = '0;
            ins.rd  = 5'(1 + rand_below(15));
            ins.rs1 = 5'(rand_below(16));
            ins.rs2 = 5'(rand_below(16));
            sel     = rand_below(100);
            if (sel < 40) begin
                ins.kind = kind_e'(int'(k_add) + rand_below(5));
                emit(ins);
            end else if (sel < 60) begin
                ins.kind = kind_e'(int'(k_addi) + rand_below(4));
                ins.imm  = rand_imm12();
                emit(ins);
            end else if (sel < 72) begin
                ins.kind = k_lw;
                ins.rs1  = '0;
                ins.imm  = 32'(4 * rand_below(dmem_words));
                emit(ins);
                if (prog_len < body_end && rand_below(2) == 1) begin
                    ins.kind = k_add;   // consumer right behind the load
                    ins.rs1  = ins.rd;
                    ins.rd   = 5'(1 + rand_below(15));
                    ins.rs2  = 5'(rand_below(16));
                    emit(ins);
                end
            end else if (sel < 84) begin
                ins.kind = k_sw;
                ins.rs1  = '0;
                ins.imm  = 32'(4 * rand_below(dmem_words));
                emit(ins);
            end else begin
                n = 1 + rand_below(4);
                if (n > body_end - prog_len) begin
                    n = body_end - prog_len;   // never past the epilogue
                end
                ins.kind = kind_e'(int'(k_beq) + rand_below(4));
                ins.imm  = 32'(4 * n);
                emit(ins);
            end
        end
        for (r = 1; r < 16; r++) begin   // dump x1..x15
            ins = '{kind: k_sw, rd: '0, rs1: '0, rs2: 5'(r), imm: 32'(4 * (47 + r))};
            emit(ins);
        end
        halt_idx = prog_len;
        ins = '{kind: k_beq, rd: '0, rs1: '0, rs2: '0, imm: '0};
        emit(ins);
    endtask

    // RV32 encoding of one entry
    function automatic logic [31:0] encode(input instr_t ins);
        isa_pkg::inst_u w;
        logic [2:0]     f3;
        w = '0;
        case (ins.kind)
            k_xor, k_xori: f3 = 3'b100;
            k_or, k_ori:   f3 = 3'b110;
            k_and, k_andi: f3 = 3'b111;
            k_lw, k_sw:    f3 = 3'b010;
            k_bne:         f3 = 3'b001;
            k_blt:         f3 = 3'b100;
            k_bge:         f3 = 3'b101;
            default:       f3 = 3'b000;   // add sub addi beq
        endcase
        if (ins.kind <= k_xor) begin
            w.r.opcode = isa_pkg::OP;
            w.r.funct7 = (ins.kind == k_sub) ? 7'h20 : 7'h00;
            w.r.rs2    = ins.rs2;
            w.r.rs1    = ins.rs1;
            w.r.funct3 = f3;
            w.r.rd     = ins.rd;
        end else if (ins.kind <= k_lw) begin
            w.i.opcode = (ins.kind == k_lw) ? isa_pkg::LOAD : isa_pkg::OP_IMM;
            w.i.imm    = ins.imm[11:0];
            w.i.rs1    = ins.rs1;
            w.i.funct3 = f3;
            w.i.rd     = ins.rd;
        end else if (ins.kind == k_sw) begin
            w.s.opcode = isa_pkg::STORE;
            w.s.imm_hi = ins.imm[11:5];
            w.s.rs2    = ins.rs2;
            w.s.rs1    = ins.rs1;
            w.s.funct3 = f3;
            w.s.imm_lo = ins.imm[4:0];
        end else begin
            w.b.opcode  = isa_pkg::BRANCH;
            w.b.imm12   = ins.imm[12];
            w.b.imm11   = ins.imm[11];
            w.b.imm10_5 = ins.imm[10:5];
            w.b.imm4_1  = ins.imm[4:1];
            w.b.rs2     = ins.rs2;
            w.b.rs1     = ins.rs1;
            w.b.funct3  = f3;
        end
        return w;
    endfunction

    // --------------------
    // instruction-level reference model
    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] a, b, res, addr;
        logic        taken;
        int          r;
        int          pc_idx;
        int          steps;
        instr_t      ins;
        for (r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        pc_idx = 0;
        steps  = 0;
        while (pc_idx != halt_idx && steps < run_timeout) begin
            ins   = prog[pc_idx];
            a     = x[ins.rs1];
            b     = x[ins.rs2];
            taken = 1'b0;
            res   = '0;
            addr  = a + ins.imm;
            case (ins.kind)
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_and:  res = a & b;
                k_or:   res = a | b;
                k_xor:  res = a ^ b;
                k_addi: res = a + ins.imm;
                k_andi: res = a & ins.imm;
                k_ori:  res = a | ins.imm;
                k_xori: res = a ^ ins.imm;
                k_lw: begin
                    res = model_mem[addr[7:2]];
                    exp_q.push_back('{we: 1'b0, adr: addr, dat: '0});
                end
                k_sw: begin
                    model_mem[addr[7:2]] = b;
                    exp_q.push_back('{we: 1'b1, adr: addr, dat: b});
                    model_stores++;
                end
                k_beq:  taken = (a == b);
                k_bne:  taken = (a != b);
                k_blt:  taken = ($signed(a) < $signed(b));
                k_bge:  taken = ($signed(a) >= $signed(b));
                default: taken = 1'b0;
            endcase
            if (ins.kind <= k_lw && ins.rd != '0) begin
                x[ins.rd] = res;
            end
            pc_idx = taken ? pc_idx + int'(ins.imm[11:2]) : pc_idx + 1;
            steps++;
        end
        if (pc_idx != halt_idx) begin
            report_failure("reference model never reached the halt loop");
        end
    endtask

    // --------------------
    // data port responder
    task automatic retire_transfer(input xfer_t t);
        xfer_t e;
        if (xfer_cnt >= exp_q.size()) begin
            report_failure("data port issued more transfers than the model");
        end
        e = exp_q[xfer_cnt];
        check_value("wb_m.we", 32'(t.we), 32'(e.we));
        check_value("wb_m.adr", t.adr, e.adr);
        if (t.we) begin
            check_value("wb_m.dat", t.dat, e.dat);
            dmem[t.adr[7:2]] = t.dat;
            store_cnt++;
        end
        xfer_cnt++;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #(drive_dly);
            if (!reset_b) begin
                wb_s = '0;
                busy = 1'b0;
            end else begin
                if (wb_s.ack) begin   // acked cycle just ended, one transfer done
                    retire_transfer(held);
                    wb_s = '0;
                    busy = 1'b0;
                end
                if (busy) begin       // request must sit still until ack
                    check_value("wb_m.stb", 32'(wb_m.stb), 32'h1);
                    check_value("wb_m.we", 32'(wb_m.we), 32'(held.we));
                    check_value("wb_m.adr", wb_m.adr, held.adr);
                    check_value("wb_m.dat", wb_m.dat, held.dat);
                end else if (wb_m.stb) begin
                    check_value("wb_m.cyc", 32'(wb_m.cyc), 32'h1);
                    held      = '{we: wb_m.we, adr: wb_m.adr, dat: wb_m.dat};
                    busy      = 1'b1;
                    wait_left = rand_below(4);   // 0..3 wait states
                end
                if (busy) begin
                    if (wait_left == 0) begin
                        wb_s.ack = 1'b1;
                        wb_s.dat = held.we ? 32'hdead_beef : dmem[held.adr[7:2]];
                    end else begin
                        wait_left--;
                    end
                end
            end
        end
    end

    // --------------------
    // main sequence
    initial begin
        int i;
        reset_b = 1'b0;
        build_program();
        for (i = 0; i < imem_words; i++) begin
            imem[i] = (i < prog_len) ? encode(prog[i]) : `RV_NOP_INST;
        end
        for (i = 0; i < dmem_words; i++) begin
            dmem[i]      = fill_word(32'(4 * i));
            model_mem[i] = fill_word(32'(4 * i));
        end
        run_model();

        repeat (4) begin   // quiet bus and pc at 0 under reset
            @(posedge clk);
            #(drive_dly);
            check_value("wb_m.cyc", 32'(wb_m.cyc), 32'h0);
            check_value("wb_m.stb", 32'(wb_m.stb), 32'h0);
            check_value("imem_addr", 32'(imem_addr), 32'h0);
        end
        reset_b = 1'b1;
        @(negedge clk);
        check_value("wb_m.cyc", 32'(wb_m.cyc), 32'h0);
        check_value("wb_m.stb", 32'(wb_m.stb), 32'h0);
        check_value("imem_addr", 32'(imem_addr), 32'h0);

        cycles = 0;
        while (store_cnt < model_stores && cycles < run_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (store_cnt < model_stores) begin
            report_failure("timed out waiting for the epilogue stores on the data port");
        end

        // halt loop, nothing more on the bus
        for (cycles = 0; cycles < quiet_cycles; cycles++) begin
            @(negedge clk);
            check_value("wb_m.cyc", 32'(wb_m.cyc), 32'h0);
            if (int'(imem_addr) < halt_idx || int'(imem_addr) > halt_idx + 2) begin
                report_failure("fetch left the halt loop");
            end
        end
        check_value("store count", 32'(store_cnt), 32'(model_stores));
        check_value("transfer count", 32'(xfer_cnt), 32'(exp_q.size()));
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/rv_pipe_top.sv ====
// top of the rv_pipe five-stage RV32 pipeline, wires fetch, decode, execute and mem/wb together
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module rv_pipe_top (
    input  logic                   clk,
    input  logic                   reset_b,
    output logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_data,
    output pipe_pkg::wb_m2s_t      wb_m,
    input  pipe_pkg::wb_s2m_t      wb_s
);

    // --------------------
    // stage to stage
    pipe_pkg::if_id_t    if_id;
    pipe_pkg::id_ex_t    id_ex;
    pipe_pkg::ex_mem_t   ex_mem;
    pipe_pkg::fwd_t      mem_fwd;
    pipe_pkg::fwd_t      wb_fwd;

    // hazard and redirect controls
    logic                freeze;
    logic                load_stall;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;

    fetch_stage u_fetch (
        .clk        (clk),
        .reset_b    (reset_b),
        .freeze     (freeze),
        .load_stall (load_stall),
        .redirect   (redirect),
        .target     (target),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .reset_b    (reset_b),
        .freeze     (freeze),
        .redirect   (redirect),
        .if_id      (if_id),
        .wb_fwd     (wb_fwd),
        .load_stall (load_stall),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset_b  (reset_b),
        .freeze   (freeze),
        .id_ex    (id_ex),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .redirect (redirect),
        .target   (target),
        .ex_mem   (ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk     (clk),
        .reset_b (reset_b),
        .ex_mem  (ex_mem),
        .wb_m    (wb_m),
        .wb_s    (wb_s),
        .freeze  (freeze),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
// memory and writeback stage of rv_pipe, Wishbone classic master, freeze, MEM/WB register
`default_nettype none
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              reset_b,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::wb_m2s_t wb_m,
    input  pipe_pkg::wb_s2m_t wb_s,
    output logic              freeze,    // holds every pipeline register
    output pipe_pkg::fwd_t    mem_fwd,
    output pipe_pkg::fwd_t    wb_fwd
);

    logic              req;
    pipe_pkg::mem_wb_t wb_r;

    // --------------------
    // Wishbone request straight off EX/MEM, stable since EX/MEM holds under freeze
    assign req      = ex_mem.mem_read | ex_mem.mem_write;
    assign wb_m.cyc = req;
    assign wb_m.stb = req;
    assign wb_m.we  = ex_mem.mem_write;
    assign wb_m.adr = ex_mem.alu_res;
    assign wb_m.dat = ex_mem.store_data;

    assign freeze = wb_m.stb && !wb_s.ack;

    // load data not ready in EX/MEM, load-use stall covers it
    assign mem_fwd.rd        = ex_mem.rd;
    assign mem_fwd.reg_write = ex_mem.reg_write && !ex_mem.mem_read;
    assign mem_fwd.value     = ex_mem.alu_res;

    // --------------------
    // MEM/WB register, load data taken with ack
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wb_r <= '0;
        end else if (!freeze) begin
            wb_r.wb_data   <= ex_mem.mem_read ? wb_s.dat : ex_mem.alu_res;
            wb_r.rd        <= ex_mem.rd;
            wb_r.reg_write <= ex_mem.reg_write;
        end
    end

    // writeback into regfile and forwarding
    assign wb_fwd.rd        = wb_r.rd;
    assign wb_fwd.reg_write = wb_r.reg_write;
    assign wb_fwd.value     = wb_r.wb_data;

    a_stb_cyc : assert property (@(posedge clk) disable iff (!reset_b)
        wb_m.stb |-> wb_m.cyc);

    // request must not move until the slave acks it
    a_req_stable : assert property (@(posedge clk) disable iff (!reset_b)
        (wb_m.stb && !wb_s.ack) |=>
            (wb_m.stb && $stable(wb_m.adr) && $stable(wb_m.we) && $stable(wb_m.dat)));

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// execute stage of rv_pipe, operand forwarding, ALU, branch resolution and the EX/MEM register
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset_b,
    input  logic                freeze,
    input  pipe_pkg::id_ex_t    id_ex,
    input  pipe_pkg::fwd_t      mem_fwd,    // EX/MEM result, loads masked off
    input  pipe_pkg::fwd_t      wb_fwd,     // MEM/WB result
    output logic                redirect,
    output logic [`RV_XLEN-1:0] target,
    output pipe_pkg::ex_mem_t   ex_mem
);

    logic [`RV_XLEN-1:0] op_a, rs2_fwd, op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic                eq, lt, taken;

    // nearer source wins, x0 never forwarded
    function automatic logic [`RV_XLEN-1:0] pick(
        input logic [`RV_REG_AW-1:0] rs,
        input logic [`RV_XLEN-1:0]   rf_val,
        input pipe_pkg::fwd_t        near,
        input pipe_pkg::fwd_t        far
    );
        if (rs == '0) begin
            return rf_val;
        end
        if (near.reg_write && near.rd == rs) begin
            return near.value;
        end
        if (far.reg_write && far.rd == rs) begin
            return far.value;
        end
        return rf_val;
    endfunction

    // --------------------
    // forwarding muxes
    assign op_a    = pick(id_ex.rs1, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign rs2_fwd = pick(id_ex.use_rs2 ? id_ex.rs2 : '0, id_ex.rs2_val, mem_fwd, wb_fwd);
    assign op_b    = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.alu_op)
            isa_pkg::SUB: alu_res = op_a - op_b;
            isa_pkg::AND: alu_res = op_a & op_b;
            isa_pkg::OR:  alu_res = op_a | op_b;
            isa_pkg::XOR: alu_res = op_a ^ op_b;
            default:      alu_res = op_a + op_b;
        endcase
    end

    // --------------------
    // branch unit, compares on the forwarded rs2, not the imm
    assign eq = (op_a == rs2_fwd);
    assign lt = ($signed(op_a) < $signed(rs2_fwd));

    always_comb begin
        case (id_ex.br_kind)
            isa_pkg::EQ: taken = eq;
            isa_pkg::NE: taken = !eq;
            isa_pkg::LT: taken = lt;
            isa_pkg::GE: taken = !lt;
            default:     taken = 1'b0;
        endcase
    end

    assign target   = id_ex.pc + id_ex.imm;
    assign redirect = taken && !freeze;   // fires once the pipe moves again

    // --------------------
    // EX/MEM register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem.alu_res    <= alu_res;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;   // 0 for branches from decode
        end
    end

    // a bubble or a non-branch must never steer fetch, and a branch carries no side effects
    a_no_redirect_none : assert property (@(posedge clk) disable iff (!reset_b)
        redirect |-> (id_ex.br_kind != isa_pkg::NONE && !id_ex.reg_write &&
                      !id_ex.mem_read && !id_ex.mem_write));

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// decode stage of rv_pipe, control decode, immediates, register file, load-use stall, ID/EX register
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module decode_stage (
    input  logic             clk,
    input  logic             reset_b,
    input  logic             freeze,
    input  logic             redirect,     // flush ID/EX on taken branch
    input  pipe_pkg::if_id_t if_id,
    input  pipe_pkg::fwd_t   wb_fwd,       // writeback port into the regfile
    output logic             load_stall,
    output pipe_pkg::id_ex_t id_ex
);

    isa_pkg::inst_u          inst;
    isa_pkg::opcode_e        opcode;
    logic                    is_op, is_imm, is_load, is_store, is_branch;
    logic                    use_rs2;
    isa_pkg::alu_op_e        alu_op;
    isa_pkg::br_kind_e       br_kind;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_REG_AW-1:0]   rs1, rs2, rd;
    logic [`RV_XLEN-1:0]     rs1_val, rs2_val;
    logic [`RV_XLEN-1:0]     regs [1:31];   // x0 is not stored
    pipe_pkg::id_ex_t        id_d;

    assign inst   = if_id.inst;
    assign opcode = inst.r.opcode;
    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;

    // --------------------
    // control decode
    assign is_op     = (opcode == isa_pkg::OP);
    assign is_imm    = (opcode == isa_pkg::OP_IMM);
    assign is_load   = (opcode == isa_pkg::LOAD);
    assign is_store  = (opcode == isa_pkg::STORE);
    assign is_branch = (opcode == isa_pkg::BRANCH);
    assign use_rs2   = is_op | is_store | is_branch;

    always_comb begin
        alu_op = isa_pkg::ADD;   // address calc for lw/sw
        if (is_op || is_imm) begin
            case (inst.r.funct3)
                3'b000:  alu_op = (is_op && inst.r.funct7[5]) ? isa_pkg::SUB : isa_pkg::ADD;
                3'b100:  alu_op = isa_pkg::XOR;
                3'b110:  alu_op = isa_pkg::OR;
                3'b111:  alu_op = isa_pkg::AND;
                default: alu_op = isa_pkg::ADD;
            endcase
        end
    end

    always_comb begin
        br_kind = isa_pkg::NONE;
        if (is_branch) begin
            case (inst.b.funct3)
                3'b000:  br_kind = isa_pkg::EQ;
                3'b001:  br_kind = isa_pkg::NE;
                3'b100:  br_kind = isa_pkg::LT;
                3'b101:  br_kind = isa_pkg::GE;
                default: br_kind = isa_pkg::NONE;
            endcase
        end
    end

    // immediate generator, sign extended
    always_comb begin
        if (is_branch) begin
            imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10_5, inst.b.imm4_1, 1'b0};
        end else if (is_store) begin
            imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        end else begin
            imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        end
    end

    // --------------------
    // register file, write at the edge
    always_ff @(posedge clk) begin
        if (wb_fwd.reg_write && wb_fwd.rd != '0) begin
            regs[wb_fwd.rd] <= wb_fwd.value;
        end
    end

    // same-cycle write shows through
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_fwd.reg_write && wb_fwd.rd == rs1) ? wb_fwd.value : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_fwd.reg_write && wb_fwd.rd == rs2) ? wb_fwd.value : regs[rs2];

    // load in EX feeding this instruction, hold one cycle
    assign load_stall = id_ex.mem_read && id_ex.rd != '0 &&
                        (id_ex.rd == rs1 || (use_rs2 && id_ex.rd == rs2));

    always_comb begin
        id_d           = '0;
        id_d.pc        = if_id.pc;
        id_d.rs1_val   = rs1_val;
        id_d.rs2_val   = rs2_val;
        id_d.imm       = imm;
        id_d.rs1       = rs1;
        id_d.rs2       = rs2;
        id_d.rd        = rd;
        id_d.use_rs2   = use_rs2;
        id_d.alu_src   = is_imm | is_load | is_store;
        id_d.alu_op    = alu_op;
        id_d.br_kind   = br_kind;
        id_d.mem_read  = is_load;
        id_d.mem_write = is_store;
        id_d.reg_write = is_op | is_imm | is_load;   // branches and stores never write
    end

    // --------------------
    // ID/EX register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            id_ex <= '0;
        end else if (!freeze) begin
            id_ex <= (redirect || load_stall) ? '0 : id_d;   // '0 is a bubble
        end
    end

    // x0 must reach execute as zero, whatever writeback is doing
    a_x0_zero : assert property (@(posedge clk) disable iff (!reset_b)
        (!freeze && !redirect && !load_stall && rs1 == '0) |=> id_ex.rs1_val == '0);

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// fetch stage of rv_pipe, owns the pc and the IF/ID register, drives the instruction port
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   freeze,       // data port waiting for ack
    input  logic                   load_stall,
    input  logic                   redirect,     // taken branch in execute
    input  logic [`RV_XLEN-1:0]    target,
    output logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_data,    // answered in the same cycle
    output pipe_pkg::if_id_t       if_id
);

    logic [`RV_XLEN-1:0] pc;

    assign imem_addr = pc[`RV_IMEM_AW+1:2];   // word address

    // redirect already gated by freeze in execute
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!load_stall && !freeze) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // --------------------
    // IF/ID register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            if_id <= '{pc: '0, inst: `RV_NOP_INST};
        end else if (!freeze) begin
            if (redirect) begin
                if_id <= '{pc: '0, inst: `RV_NOP_INST};   // squash the wrong-path fetch
            end else if (!load_stall) begin
                if_id <= '{pc: pc, inst: imem_data};
            end
        end
    end

    // branch targets come back from execute, offsets must keep them aligned
    a_pc_aligned : assert property (@(posedge clk) disable iff (!reset_b)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
// pipeline register layouts and Wishbone bus bundles shared across the rv_pipe stages
`default_nettype none

`include "rv_pipe_config.svh"

package pipe_pkg;

    // --------------------
    // pipeline registers
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   rs1_val;   // regfile read, before forwarding
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;       // branch offset already shifted
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic                  use_rs2;
        logic                  alu_src;   // 1 selects imm as operand b
        isa_pkg::alu_op_e      alu_op;
        isa_pkg::br_kind_e     br_kind;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   alu_res;      // also the load/store byte address
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   wb_data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_write;
    } mem_wb_t;

    // a forwarding source, ex/mem or writeback
    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   value;
    } fwd_t;

    // --------------------
    // Wishbone classic, master to slave and back
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
// RV32 subset encodings and instruction formats, referenced by decode and the testbench encoder
`default_nettype none

`include "rv_pipe_config.svh"

package isa_pkg;

    // --------------------
    // opcodes and operation kinds
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // add sub and or xor
        OP_IMM = 7'b0010011,   // addi andi ori xori
        LOAD   = 7'b0000011,   // lw only
        STORE  = 7'b0100011,   // sw only
        BRANCH = 7'b1100011    // beq bne blt bge
    } opcode_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;

    typedef enum logic [2:0] {NONE, EQ, NE, LT, GE} br_kind_e;   // NONE is the bubble value

    // --------------------
    // the four formats, msb first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;   // imm[11:5]
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;   // imm[4:0]
        opcode_e               opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        opcode_e               opcode;
    } b_fmt_t;

    // one instruction word, read through whichever format applies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } inst_u;

endpackage

`default_nettype wire

// ==== hdl/rv_pipe_config.svh ====
// shared widths and encodings for the rv_pipe RTL and testbench, pulled in with `include
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// data path and byte address width
`define RV_XLEN 32

// instruction memory word address width, 1k words
`define RV_IMEM_AW 10

// register number width, x0..x31
`define RV_REG_AW 5

// addi x0,x0,0 used as the fetch bubble
`define RV_NOP_INST 32'h0000_0013

`endif
